//--- rtl/armPkg.sv
/* Widths, instruction field positions, instruction class, ALU operation,
   condition code and immediate form enums, and the NZCV flag struct */
`default_nettype none

package armPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;
   localparam int pcRegNum     = 15;     // Reads as PC + 8
   localparam int pcStep       = 4;
   localparam int pcReadOffset = 8;

   // Instruction field positions
   localparam int condMsb  = 31;
   localparam int condLsb  = 28;
   localparam int opMsb    = 27;
   localparam int opLsb    = 26;
   localparam int iBit     = 25;         // Immediate form of data processing
   localparam int cmdMsb   = 24;
   localparam int cmdLsb   = 21;
   localparam int sBit     = 20;         // Update flags
   localparam int lBit     = 20;         // Load when set, store when clear
   localparam int rnMsb    = 19;
   localparam int rnLsb    = 16;
   localparam int rdMsb    = 15;
   localparam int rdLsb    = 12;
   localparam int rmMsb    = 3;
   localparam int rmLsb    = 0;
   localparam int imm8Msb  = 7;
   localparam int imm12Msb = 11;
   localparam int imm24Msb = 23;

   typedef enum logic [1:0] {dataProc = 2'b00, memAccess = 2'b01, branch = 2'b10} opClass_t;

   typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluEor} aluOp_t;

   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl
   } cond_t;

   typedef enum logic [1:0] {imm8, imm12, imm24Branch} immSrc_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

endpackage

`default_nettype wire

//--- rtl/ctrlIf.sv
/* Control and flag bundle between decoder, condition unit and datapath */
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf import armPkg::*; ();

   logic [1:0] regSrc;       // Bit 0 R15 as rn, bit 1 rd as second read
   immSrc_t    immSrc;
   logic       aluSrc;
   aluOp_t     aluOp;
   logic       memToReg;
   logic       regW, memW, pcS;
   logic [1:0] flagW;        // NZ on bit 1, CV on bit 0
   logic       regWrite, memWrite, pcSrc;
   flags_t     aluFlags;

   modport decoderSide (output regSrc, immSrc, aluSrc, aluOp, memToReg,
                        output regW, memW, pcS, flagW);
   modport condSide (input regW, memW, pcS, flagW, aluFlags,
                     output regWrite, memWrite, pcSrc);
   modport datapathSide (input regSrc, immSrc, aluSrc, aluOp, memToReg,
                         input regWrite, pcSrc,
                         output aluFlags);

endinterface

`default_nettype wire

//--- rtl/instrDecoder.sv
/* Main decoder and ALU decoder producing the control word */
`timescale 1ns/100ps
`default_nettype none

module instrDecoder import armPkg::*; (
   input logic [condMsb:rdLsb] instr,
   ctrlIf.decoderSide          ctrl
);

   opClass_t   op;
   logic [3:0] cmd;
   logic       sFlag;
   logic       isDp, isBranch;
   logic       writesRd;     // Before CMP suppression
   logic       noWrite;
   logic       rdIsPc;
   logic       legalCmd;

   assign op     = opClass_t'(instr[opMsb:opLsb]);
   assign cmd    = instr[cmdMsb:cmdLsb];
   assign sFlag  = instr[sBit];
   assign rdIsPc = (instr[rdMsb:rdLsb] == regAddrWidth'(pcRegNum));

   // Main decoder
   always_comb begin
      ctrl.regSrc   = 2'b00;
      ctrl.immSrc   = imm8;
      ctrl.aluSrc   = 1'b0;
      ctrl.memToReg = 1'b0;
      ctrl.memW     = 1'b0;
      writesRd      = 1'b0;
      isDp          = 1'b0;
      isBranch      = 1'b0;
      case (op)
         dataProc: begin
            isDp        = 1'b1;
            writesRd    = 1'b1;
            ctrl.aluSrc = instr[iBit];   // imm8 or rm
         end
         memAccess: begin
            ctrl.immSrc = imm12;
            ctrl.aluSrc = 1'b1;
            if (instr[lBit]) begin
               writesRd      = 1'b1;
               ctrl.memToReg = 1'b1;
            end else begin
               ctrl.memW      = 1'b1;
               ctrl.regSrc[1] = 1'b1;    // Store data from rd
            end
         end
         branch: begin
            isBranch       = 1'b1;
            ctrl.immSrc    = imm24Branch;
            ctrl.aluSrc    = 1'b1;
            ctrl.regSrc[0] = 1'b1;
         end
         default: ;
      endcase
   end

   // ALU decoder
   always_comb begin
      ctrl.aluOp = aluAdd;     // Address and branch target
      noWrite    = 1'b0;
      legalCmd   = 1'b1;
      if (isDp) begin
         case (cmd)
            4'b0100: ctrl.aluOp = aluAdd;
            4'b0010: ctrl.aluOp = aluSub;
            4'b0000: ctrl.aluOp = aluAnd;
            4'b1100: ctrl.aluOp = aluOrr;
            4'b0001: ctrl.aluOp = aluEor;
            4'b1010: begin                 // CMP
               ctrl.aluOp = aluSub;
               noWrite    = 1'b1;
            end
            default: legalCmd = 1'b0;
         endcase
      end
   end

   // C and V only from the adder
   assign ctrl.flagW[1] = isDp & sFlag;
   assign ctrl.flagW[0] = isDp & sFlag & (ctrl.aluOp inside {aluAdd, aluSub});

   // A write to R15 goes through the PC instead of the register file
   assign ctrl.regW = writesRd & ~noWrite & ~rdIsPc;
   assign ctrl.pcS  = isBranch | (writesRd & ~noWrite & rdIsPc);

   always_comb begin
      if (!$isunknown(instr)) begin
         assert final (op inside {dataProc, memAccess, branch} && legalCmd &&
                       instr[condMsb:condLsb] != 4'b1111)
            else $error("instrDecoder: instruction outside the supported subset");
      end
   end

endmodule

`default_nettype wire

//--- rtl/condUnit.sv
/* NZCV flag register, condition check and write gating */
`timescale 1ns/100ps
`default_nettype none

module condUnit import armPkg::*; (
   input logic     clk,
   input logic     reset,
   input cond_t    cond,
   ctrlIf.condSide ctrl
);

   flags_t     flags;
   logic       condEx;
   logic       ge;
   logic [1:0] flagWrite;

   assign ge = (flags.n == flags.v);

   always_comb begin
      case (cond)
         condEq:  condEx = flags.z;
         condNe:  condEx = ~flags.z;
         condCs:  condEx = flags.c;
         condCc:  condEx = ~flags.c;
         condMi:  condEx = flags.n;
         condPl:  condEx = ~flags.n;
         condVs:  condEx = flags.v;
         condVc:  condEx = ~flags.v;
         condHi:  condEx = flags.c & ~flags.z;
         condLs:  condEx = ~flags.c | flags.z;
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags.z & ge;
         condLe:  condEx = flags.z | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;   // 4'b1111 not in the subset
      endcase
   end

   assign flagWrite = ctrl.flagW & {2{condEx}};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagWrite[1]) begin
            flags.n <= ctrl.aluFlags.n;
            flags.z <= ctrl.aluFlags.z;
         end
         if (flagWrite[0]) begin
            flags.c <= ctrl.aluFlags.c;
            flags.v <= ctrl.aluFlags.v;
         end
      end
   end

   assign ctrl.regWrite = ctrl.regW & condEx;
   assign ctrl.memWrite = ctrl.memW & condEx;
   assign ctrl.pcSrc    = ctrl.pcS & condEx;

   // Loads and stores never share a cycle
   assert property (@(posedge clk) disable iff (reset) !(ctrl.memWrite && ctrl.regWrite))
      else $error("condUnit: memWrite and regWrite high together");

endmodule

`default_nettype wire

//--- rtl/regFile.sv
/* Fifteen-entry register file, two read ports, one write port,
   R15 returned from the PC side */
`timescale 1ns/100ps
`default_nettype none

module regFile import armPkg::*; #(
   parameter int width = dataWidth
) (
   input  logic                    clk,
   input  logic                    we,
   input  logic [regAddrWidth-1:0] ra1,
   input  logic [regAddrWidth-1:0] ra2,
   input  logic [regAddrWidth-1:0] wa,
   input  logic [width-1:0]        wd,
   input  logic [width-1:0]        r15,
   output logic [width-1:0]        rd1,
   output logic [width-1:0]        rd2
);

   logic [width-1:0] regs [0:pcRegNum-1];   // R0 to R14

   always_ff @(posedge clk) begin
      if (we) regs[wa] <= wd;
   end

   assign rd1 = (ra1 == regAddrWidth'(pcRegNum)) ? r15 : regs[ra1];
   assign rd2 = (ra2 == regAddrWidth'(pcRegNum)) ? r15 : regs[ra2];

   // R15 writes are routed to the PC by the decoder
   assert property (@(posedge clk) we |-> wa != regAddrWidth'(pcRegNum))
      else $error("regFile: write to register 15");

endmodule

`default_nettype wire

//--- rtl/alu.sv
/* ALU with add, subtract, AND, ORR and EOR plus NZCV generation */
`timescale 1ns/100ps
`default_nettype none

module alu import armPkg::*; #(
   parameter int width = dataWidth
) (
   input  logic [width-1:0] a,
   input  logic [width-1:0] b,
   input  aluOp_t           op,
   output logic [width-1:0] result,
   output flags_t           flags
);

   logic             sub;
   logic             arith;
   logic [width-1:0] bInv;
   logic [width:0]   sum;      // Carry out on top bit

   assign sub   = (op == aluSub);
   assign arith = (op == aluAdd) || sub;

   // Subtract as a + ~b + 1
   assign bInv = sub ? ~b : b;
   assign sum  = {1'b0, a} + {1'b0, bInv} + {{width{1'b0}}, sub};

   always_comb begin
      case (op)
         aluAdd,
         aluSub:  result = sum[width-1:0];
         aluAnd:  result = a & b;
         aluOrr:  result = a | b;
         aluEor:  result = a ^ b;
         default: result = '0;
      endcase
   end

   assign flags.n = result[width-1];
   assign flags.z = (result == '0);
   assign flags.c = arith & sum[width];
   // Operands of equal sign giving a result of the other sign
   assign flags.v = arith & ~(a[width-1] ^ b[width-1] ^ sub) &
                    (a[width-1] ^ sum[width-1]);

endmodule

`default_nettype wire

//--- rtl/datapath.sv
/* PC register and next-PC select, immediate extension, register file,
   ALU and the operand and writeback muxes */
`timescale 1ns/100ps
`default_nettype none

module datapath import armPkg::*; #(
   parameter int width = dataWidth
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [width-1:0] instr,
   output logic [width-1:0] pc,
   output logic [width-1:0] dataAdr,
   output logic [width-1:0] writeData,
   input  logic [width-1:0] readData,
   ctrlIf.datapathSide      ctrl
);

   logic [width-1:0]        pcNext, pcPlus4, pcPlus8;
   logic [width-1:0]        extImm, srcA, srcB, rd2, aluResult, result;
   logic [regAddrWidth-1:0] ra1, ra2;

   assign pcPlus4 = pc + width'(pcStep);
   assign pcPlus8 = pc + width'(pcReadOffset);
   assign pcNext  = ctrl.pcSrc ? result : pcPlus4;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) pc <= '0;
      else       pc <= pcNext;
   end

   always_comb begin
      case (ctrl.immSrc)
         imm8:        extImm = {{(width-imm8Msb-1){1'b0}}, instr[imm8Msb:0]};
         imm12:       extImm = {{(width-imm12Msb-1){1'b0}}, instr[imm12Msb:0]};
         imm24Branch: extImm = {{(width-imm24Msb-3){instr[imm24Msb]}},
                                instr[imm24Msb:0], 2'b00};
         default:     extImm = '0;
      endcase
   end

   // Branch target is R15 plus offset
   assign ra1 = ctrl.regSrc[0] ? regAddrWidth'(pcRegNum) : instr[rnMsb:rnLsb];
   assign ra2 = ctrl.regSrc[1] ? instr[rdMsb:rdLsb] : instr[rmMsb:rmLsb];

   regFile #(.width(width)) rf (
      .clk (clk),
      .we  (ctrl.regWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (instr[rdMsb:rdLsb]),
      .wd  (result),
      .r15 (pcPlus8),
      .rd1 (srcA),
      .rd2 (rd2)
   );

   assign srcB = ctrl.aluSrc ? extImm : rd2;

   alu #(.width(width)) aluUnit (
      .a      (srcA),
      .b      (srcB),
      .op     (ctrl.aluOp),
      .result (aluResult),
      .flags  (ctrl.aluFlags)
   );

   assign result    = ctrl.memToReg ? readData : aluResult;
   assign dataAdr   = aluResult;
   assign writeData = rd2;   // Store data from rd

endmodule

`default_nettype wire

//--- rtl/armCore.sv
/* Single-cycle ARM core top level with plain memory ports */
`timescale 1ns/100ps
`default_nettype none

module armCore import armPkg::*; #(
   parameter int width = dataWidth
) (
   input  logic             clk,
   input  logic             reset,
   output logic [width-1:0] pc,
   input  logic [width-1:0] instr,
   output logic             memWrite,
   output logic [width-1:0] dataAdr,
   output logic [width-1:0] writeData,
   input  logic [width-1:0] readData
);

   ctrlIf ctrl ();

   instrDecoder dec (
      .instr (instr[condMsb:rdLsb]),
      .ctrl  (ctrl.decoderSide)
   );

   condUnit cu (
      .clk   (clk),
      .reset (reset),
      .cond  (cond_t'(instr[condMsb:condLsb])),
      .ctrl  (ctrl.condSide)
   );

   datapath #(.width(width)) dp (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .pc        (pc),
      .dataAdr   (dataAdr),
      .writeData (writeData),
      .readData  (readData),
      .ctrl      (ctrl.datapathSide)
   );

   assign memWrite = ctrl.memWrite;   // Gated store enable

endmodule

`default_nettype wire

//--- dv/armChecker.sv
/* Instruction-level reference model of the core with its own registers,
   flags and data memory, compared against the DUT ports on each rising edge */
`timescale 1ns/100ps
`default_nettype none

module armChecker #(
   parameter logic [31:0] fillMask = 32'h5a5a_a5a5
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [31:0] pc,
   input  logic [31:0] instr,
   input  logic        memWrite,
   input  logic [31:0] dataAdr,
   input  logic [31:0] writeData,
   output int          errorCount,
   output int          instrCount
);

   localparam int numTests   = 5;
   localparam int tReset     = 0;
   localparam int tDataProc  = 1;
   localparam int tCond      = 2;
   localparam int tLoadStore = 3;
   localparam int tBranch    = 4;

   logic [31:0] regs [0:14];
   logic [31:0] dmem [logic [31:0]];   // Words stored by the model
   logic [31:0] pcModel;
   logic        fN, fZ, fC, fV;
   logic        afterBranch;
   int          checks [numTests];
   int          errors [numTests];

   initial begin
      for (int i = 0; i < 15; i++) regs[i] = '0;
      for (int i = 0; i < numTests; i++) begin
         checks[i] = 0;
         errors[i] = 0;
      end
      errorCount  = 0;
      instrCount  = 0;
      pcModel     = '0;
      afterBranch = 1'b0;
   end

   function automatic string testLabel(input int t);
      case (t)
         tReset:     return "reset";
         tDataProc:  return "dataProc";
         tCond:      return "flagsCond";
         tLoadStore: return "loadStore";
         default:    return "branch";
      endcase
   endfunction

   task automatic compare(input int t, input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks[t]++;
      if (actual !== expected) begin
         errors[t]++;
         errorCount++;
         $display("Mismatch %s (%s): expected %h, actual %h at %0t",
                  testLabel(t), what, expected, actual, $time);
      end
   endtask

   function automatic logic [31:0] readReg(input logic [3:0] r);
      return (r == 4'd15) ? pcModel + 32'd8 : regs[r];   // R15 reads ahead
   endfunction

   function automatic logic condPass(input logic [3:0] cc);
      case (cc)
         4'h0:    return fZ;
         4'h1:    return !fZ;
         4'h2:    return fC;
         4'h3:    return !fC;
         4'h4:    return fN;
         4'h5:    return !fN;
         4'h6:    return fV;
         4'h7:    return !fV;
         4'h8:    return fC && !fZ;
         4'h9:    return !fC || fZ;
         4'ha:    return fN == fV;
         4'hb:    return fN != fV;
         4'hc:    return !fZ && (fN == fV);
         4'hd:    return fZ || (fN != fV);
         default: return 1'b1;
      endcase
   endfunction

   task automatic checkInstr();
      logic [3:0]  rd, cmd;
      logic        pass, store, arith, cOut, vOut;
      logic [31:0] a, b, res, adr, nextPc;
      begin
         rd    = instr[15:12];
         cmd   = instr[24:21];
         pass  = condPass(instr[31:28]);
         store = (instr[27:26] == 2'b01) && !instr[20];
         compare(afterBranch ? tBranch : tReset, "pc", pcModel, pc);
         compare(tCond, "memWrite", {31'b0, store && pass}, {31'b0, memWrite});
         a           = readReg(instr[19:16]);
         nextPc      = pcModel + 32'd4;
         afterBranch = 1'b0;
         case (instr[27:26])
            2'b00: begin
               b     = instr[25] ? {24'b0, instr[7:0]} : readReg(instr[3:0]);
               cOut  = 1'b0;
               vOut  = 1'b0;
               arith = 1'b1;
               case (cmd)
                  4'b0100: begin
                     {cOut, res} = {1'b0, a} + {1'b0, b};
                     vOut = (a[31] == b[31]) && (res[31] != a[31]);
                  end
                  4'b0010, 4'b1010: begin
                     res  = a - b;
                     cOut = (a >= b);   // Carry means no borrow
                     vOut = (a[31] != b[31]) && (res[31] != a[31]);
                  end
                  4'b0000: res = a & b;
                  4'b1100: res = a | b;
                  default: res = a ^ b;
               endcase
               if (!(cmd inside {4'b0100, 4'b0010, 4'b1010})) arith = 1'b0;
               compare(tDataProc, "alu result", res, dataAdr);
               if (pass) begin
                  if (cmd != 4'b1010) regs[rd] = res;   // CMP keeps rd
                  if (instr[20]) begin
                     fN = res[31];
                     fZ = (res == 32'h0);
                     if (arith) begin
                        fC = cOut;
                        fV = vOut;
                     end
                  end
               end
            end
            2'b01: begin
               adr = a + {20'b0, instr[11:0]};
               compare(tLoadStore, "address", adr, dataAdr);
               if (pass && store) begin
                  compare(tLoadStore, "store data", readReg(rd), writeData);
                  dmem[adr] = readReg(rd);
               end else if (pass) begin
                  regs[rd] = dmem.exists(adr) ? dmem[adr] : (adr ^ fillMask);
               end
            end
            default: begin
               adr = pcModel + 32'd8 + {{6{instr[23]}}, instr[23:0], 2'b00};
               compare(tBranch, "branch target", adr, dataAdr);
               if (pass) nextPc = adr;
               afterBranch = 1'b1;
            end
         endcase
         pcModel = nextPc;
         instrCount++;
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         compare(tReset, "pc in reset", 32'h0, pc);
         compare(tReset, "memWrite in reset", 32'h0, {31'b0, memWrite});
         pcModel     = '0;
         afterBranch = 1'b0;
         {fN, fZ, fC, fV} = 4'b0000;
      end else begin
         checkInstr();
      end
   end

   task automatic printSummary();
      int total;
      total = 0;
      for (int i = 0; i < numTests; i++) begin
         $display("Test %s: %0d checks, %0d errors", testLabel(i), checks[i], errors[i]);
         total += checks[i];
      end
      $display("Totals: %0d instructions, %0d checks, %0d errors",
               instrCount, total, errorCount);
   endtask

endmodule

`default_nettype wire

//--- dv/armCoreTb.sv
/* Testbench for the core with clock, reset, random program generation,
   instruction and data memory models, DUT and checker instances */
`timescale 1ns/100ps
`default_nettype none

module armCoreTb;

   localparam int          memWords      = 256;
   localparam int          runCycles     = 400;
   localparam int          timeoutCycles = 1000;
   localparam logic [31:0] fillMask      = 32'h5a5a_a5a5;

   logic        clk;
   logic        reset;
   logic [31:0] pc, instr, dataAdr, writeData, readData;
   logic        memWrite;
   logic [31:0] imem [0:memWords-1];
   logic [31:0] dmem [logic [31:0]];
   integer      seed;
   int          errorCount;
   int          instrCount;
   int          cycles;

   armCore uut (
      .clk       (clk),
      .reset     (reset),
      .pc        (pc),
      .instr     (instr),
      .memWrite  (memWrite),
      .dataAdr   (dataAdr),
      .writeData (writeData),
      .readData  (readData)
   );

   armChecker #(.fillMask(fillMask)) chk (
      .clk        (clk),
      .reset      (reset),
      .pc         (pc),
      .instr      (instr),
      .memWrite   (memWrite),
      .dataAdr    (dataAdr),
      .writeData  (writeData),
      .errorCount (errorCount),
      .instrCount (instrCount)
   );

   always #2 clk = ~clk;

   function automatic int randBelow(input int n);
      return int'({$random(seed)} % n);
   endfunction

   // Random legal encoding for word idx with branch targets inside memory
   function automatic logic [31:0] randomInstr(input int idx);
      logic [3:0] cc, rn, rd, cmd;
      logic       s;
      int         kind, lo, hi, off;
      begin
         cc   = (randBelow(2) == 0) ? 4'he : 4'(randBelow(15));
         rn   = 4'(randBelow(16));
         rd   = 4'(randBelow(15));
         kind = randBelow(20);
         if (kind < 12) begin
            case (randBelow(6))
               0:       cmd = 4'b0100;
               1:       cmd = 4'b0010;
               2:       cmd = 4'b0000;
               3:       cmd = 4'b1100;
               4:       cmd = 4'b0001;
               default: cmd = 4'b1010;   // CMP
            endcase
            s = (cmd == 4'b1010) ? 1'b1 : 1'(randBelow(2));
            if (randBelow(2) == 1)
               return {cc, 3'b001, cmd, s, rn, rd, 4'h0, 8'(randBelow(256))};
            return {cc, 3'b000, cmd, s, rn, rd, 8'h00, 4'(randBelow(16))};
         end else if (kind < 17) begin
            return {cc, 3'b010, 4'b1100, 1'(randBelow(2)), rn, rd, 12'(randBelow(4096))};
         end
         lo  = -idx - 2;
         hi  = memWords - 3 - idx;
         off = lo + randBelow(hi - lo + 1);
         return {cc, 4'b1010, 24'(off)};
      end
   endfunction

   function automatic logic [31:0] readWord(input logic [31:0] adr);
      return dmem.exists(adr) ? dmem[adr] : (adr ^ fillMask);
   endfunction

   // Fetch on the falling edge and return load data once dataAdr has settled
   always @(negedge clk) begin
      instr = imem[pc[9:2]];
      #1 readData = readWord(dataAdr);
   end

   always @(posedge clk) begin
      if (!reset && memWrite) dmem[dataAdr] = writeData;
   end

   initial begin
      seed     = 32'hd325_6be7;
      clk      = 1'b0;
      reset    <= 1'b1;
      readData = '0;
      for (int i = 0; i < 15; i++)   // SUB Ri, R15, R15 clears every register
         imem[i] = {4'he, 3'b000, 4'b0010, 1'b0, 4'hf, 4'(i), 8'h00, 4'hf};
      for (int i = 15; i < memWords; i++) imem[i] = randomInstr(i);
      instr = imem[0];
      repeat (2) @(negedge clk);
      reset  = 1'b0;
      cycles = 0;
      while (instrCount < runCycles && cycles < timeoutCycles) begin
         @(negedge clk);
         cycles++;
      end
      chk.printSummary();
      if (instrCount < runCycles) begin
         $display("Timeout: only %0d of %0d instructions checked", instrCount, runCycles);
         $display("Simulation finished: FAIL");
      end else if (errorCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- armCore.f
rtl/armPkg.sv
rtl/ctrlIf.sv
rtl/instrDecoder.sv
rtl/condUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/datapath.sv
rtl/armCore.sv
dv/armChecker.sv
dv/armCoreTb.sv
